// ==== all.f ====
hdl/dcache_pkg.sv
hdl/way_store.sv
hdl/way_select.sv
hdl/flush_counter.sv
hdl/dcache_fsm.sv
hdl/dcache_top.sv
tests/mem_model.sv
tests/dcache_tb.sv

// ==== hdl/dcache_fsm.sv ====
// cache controller that sequences hits, victim writeback, block fill, store miss and halt flush
// memory side holds dREN or dWEN with daddr until dwait falls for each word
`default_nettype none

module dcache_fsm #(
    parameter int SET_BITS = dcache_pkg::IDX_W
) (
    input  wire logic                          CLK,
    input  wire logic                          nRST,
    input  wire logic                          dmemREN,
    input  wire logic                          dmemWEN,
    input  wire logic                          halt,
    input  wire logic                          dwait,
    input  wire logic                          hit,
    input  wire logic                          victim_dirty,
    input  wire logic                          flush_dirty,
    input  wire logic                          flush_done,
    input  wire logic                          hit_way,
    input  wire logic                          victim_way,
    input  wire logic                          flush_way,
    input  wire dcache_pkg::word_t             dmemaddr,
    input  wire dcache_pkg::word_t             dmemstore,
    input  wire dcache_pkg::word_t             dload,
    input  wire dcache_pkg::block_t            hit_block,
    input  wire dcache_pkg::block_t            victim_block,
    input  wire dcache_pkg::block_t            flush_block,
    input  wire logic [dcache_pkg::TAG_W-1:0]  victim_tag,
    input  wire logic [dcache_pkg::TAG_W-1:0]  flush_tag,
    input  wire logic [SET_BITS-1:0]           flush_idx,
    output logic                               dhit,
    output logic                               flushed,
    output logic                               dREN,
    output logic                               dWEN,
    output dcache_pkg::word_t                  daddr,
    output dcache_pkg::word_t                  dstore,
    output dcache_pkg::word_t                  dmemload,
    output logic [1:0]                         tag_wen,
    output logic [1:0]                         data_wen,
    output dcache_pkg::frame_tag_t             new_tag,
    output dcache_pkg::block_t                 new_block,
    output logic                               lru_update,
    output logic                               lru_way,
    output logic                               flush_step,
    output logic                               flush_active
);

    localparam int OFF_LSB = dcache_pkg::BYTE_W;
    localparam int IDX_LSB = OFF_LSB + dcache_pkg::BLK_W;
    localparam int TAG_LSB = IDX_LSB + SET_BITS;

    dcache_pkg::cache_state_t state, next_state;

    logic [dcache_pkg::TAG_W-1:0] req_tag;
    logic [SET_BITS-1:0]          req_idx;
    logic [dcache_pkg::BLK_W-1:0] req_off;
    logic                         req;
    logic                         do_store;

    assign req_tag = dmemaddr[TAG_LSB +: dcache_pkg::TAG_W];
    assign req_idx = dmemaddr[IDX_LSB +: SET_BITS];
    assign req_off = dmemaddr[OFF_LSB +: dcache_pkg::BLK_W];
    assign req     = dmemREN || dmemWEN;

    // word address built from tag, index and word offset with zeros above the tag
    function automatic dcache_pkg::word_t blk_addr(
        input logic [dcache_pkg::TAG_W-1:0] tag,
        input logic [SET_BITS-1:0]          idx,
        input logic [dcache_pkg::BLK_W-1:0] off
    );
        dcache_pkg::word_t a;
        a = '0;
        a[TAG_LSB +: dcache_pkg::TAG_W] = tag;
        a[IDX_LSB +: SET_BITS]          = idx;
        a[OFF_LSB +: dcache_pkg::BLK_W] = off;
        return a;
    endfunction

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    assign flushed      = (state == dcache_pkg::HALTED);
    assign flush_active = (state inside {dcache_pkg::FLUSH_CHECK, dcache_pkg::FLUSH1,
                                         dcache_pkg::FLUSH2, dcache_pkg::HALTED});

    always_comb begin
        next_state = state;
        dhit       = 1'b0;
        dREN       = 1'b0;
        dWEN       = 1'b0;
        daddr      = '0;
        dstore     = '0;
        dmemload   = '0;
        tag_wen    = '0;
        data_wen   = '0;
        new_tag    = '0;
        new_block  = victim_block;
        lru_update = 1'b0;
        lru_way    = hit_way;
        flush_step = 1'b0;
        do_store   = 1'b0;
        case (state)
            dcache_pkg::IDLE: begin
                if (halt) begin
                    next_state = dcache_pkg::FLUSH_CHECK;
                end else if (req && hit) begin
                    dhit       = 1'b1;
                    dmemload   = hit_block[req_off];
                    lru_update = 1'b1;
                    do_store   = dmemWEN;
                end else if (req) begin
                    next_state = victim_dirty ? dcache_pkg::WB1 : dcache_pkg::LOAD1;
                end
            end
            dcache_pkg::WB1, dcache_pkg::WB2: begin
                dWEN   = 1'b1;
                daddr  = blk_addr(victim_tag, req_idx, state == dcache_pkg::WB2);
                dstore = victim_block[state == dcache_pkg::WB2];
                if (!dwait) begin
                    next_state = (state == dcache_pkg::WB1) ? dcache_pkg::WB2
                                                            : dcache_pkg::LOAD1;
                end
            end
            dcache_pkg::LOAD1: begin
                dREN  = 1'b1;
                daddr = blk_addr(req_tag, req_idx, 1'b0);
                if (!dwait) begin
                    // frame stays invalid until the second word lands
                    new_block[0]         = dload;
                    new_tag.tag          = req_tag;
                    tag_wen[victim_way]  = 1'b1;
                    data_wen[victim_way] = 1'b1;
                    next_state           = dcache_pkg::LOAD2;
                end
            end
            dcache_pkg::LOAD2: begin
                dREN  = 1'b1;
                daddr = blk_addr(req_tag, req_idx, 1'b1);
                if (!dwait) begin
                    new_block[1]         = dload;
                    new_tag.valid        = 1'b1;
                    new_tag.tag          = req_tag;
                    tag_wen[victim_way]  = 1'b1;
                    data_wen[victim_way] = 1'b1;
                    // a read finishes as a hit back in IDLE
                    next_state = dmemWEN ? dcache_pkg::STORE : dcache_pkg::IDLE;
                end
            end
            dcache_pkg::STORE: begin
                dhit       = 1'b1;
                lru_update = 1'b1;
                do_store   = 1'b1;
                next_state = dcache_pkg::IDLE;
            end
            dcache_pkg::FLUSH_CHECK: begin
                if (flush_done) begin
                    next_state = dcache_pkg::HALTED;
                end else if (flush_dirty) begin
                    next_state = dcache_pkg::FLUSH1;
                end else begin
                    flush_step = 1'b1;
                end
            end
            dcache_pkg::FLUSH1, dcache_pkg::FLUSH2: begin
                dWEN   = 1'b1;
                daddr  = blk_addr(flush_tag, flush_idx, state == dcache_pkg::FLUSH2);
                dstore = flush_block[state == dcache_pkg::FLUSH2];
                if (!dwait && state == dcache_pkg::FLUSH1) begin
                    next_state = dcache_pkg::FLUSH2;
                end else if (!dwait) begin
                    // frame goes clean and invalid once written back
                    tag_wen[flush_way] = 1'b1;
                    flush_step         = 1'b1;
                    next_state         = dcache_pkg::FLUSH_CHECK;
                end
            end
            dcache_pkg::HALTED: begin
                next_state = dcache_pkg::HALTED;
            end
            default: begin
                next_state = dcache_pkg::IDLE;
            end
        endcase

        // store word merged into the hit frame and the frame marked dirty
        if (do_store) begin
            new_block          = hit_block;
            new_block[req_off] = dmemstore;
            new_tag.valid      = 1'b1;
            new_tag.dirty      = 1'b1;
            new_tag.tag        = req_tag;
            tag_wen[hit_way]   = 1'b1;
            data_wen[hit_way]  = 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/dcache_pkg.sv ====
// shared types and address field widths for the two-way data cache
// every cache module refers to these by scoped name
`default_nettype none

package dcache_pkg;

    typedef logic [31:0] word_t;

    // address layout from the top is tag, index, word offset and byte offset
    localparam int TAG_W  = 26;
    localparam int IDX_W  = 3;
    localparam int BLK_W  = 1;
    localparam int BYTE_W = 2;

    // one frame's tag store entry
    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } frame_tag_t;

    // data words of one frame indexed by word offset
    typedef logic [2**BLK_W-1:0][31:0] block_t;

    typedef enum logic [3:0] {
        IDLE,
        WB1,
        WB2,
        LOAD1,
        LOAD2,
        STORE,
        FLUSH_CHECK,
        FLUSH1,
        FLUSH2,
        HALTED
    } cache_state_t;

endpackage

`default_nettype wire

// ==== hdl/dcache_top.sv ====
// top level of the two-way set-associative write-back data cache between processor and memory
// SET_BITS sets the number of sets and is passed to every submodule
`default_nettype none

module dcache_top #(
    parameter int SET_BITS = dcache_pkg::IDX_W
) (
    input  wire logic               CLK,
    input  wire logic               nRST,
    input  wire logic               dmemREN,
    input  wire logic               dmemWEN,
    input  wire logic               halt,
    input  wire dcache_pkg::word_t  dmemaddr,
    input  wire dcache_pkg::word_t  dmemstore,
    output logic                    dhit,
    output logic                    flushed,
    output dcache_pkg::word_t       dmemload,
    output logic                    dREN,
    output logic                    dWEN,
    output dcache_pkg::word_t       daddr,
    output dcache_pkg::word_t       dstore,
    input  wire logic               dwait,
    input  wire dcache_pkg::word_t  dload
);

    localparam int IDX_LSB = dcache_pkg::BYTE_W + dcache_pkg::BLK_W;
    localparam int TAG_LSB = IDX_LSB + SET_BITS;

    logic [dcache_pkg::TAG_W-1:0] req_tag;
    logic [SET_BITS-1:0]          req_idx, rd_idx, flush_idx;
    logic       hit, hit_way, victim_way, victim_dirty, lru_update, lru_way;
    logic       flush_way, flush_done, flush_step, flush_active, flush_dirty;
    logic [1:0] tag_wen, data_wen;

    dcache_pkg::frame_tag_t tag_rd [2];
    dcache_pkg::block_t     data_rd [2];
    dcache_pkg::frame_tag_t new_tag, flush_entry;
    dcache_pkg::block_t     new_block;

    assign req_tag = dmemaddr[TAG_LSB +: dcache_pkg::TAG_W];
    assign req_idx = dmemaddr[IDX_LSB +: SET_BITS];

    // the flush index picks the set during a flush and the request index otherwise
    assign rd_idx      = flush_active ? flush_idx : req_idx;
    assign flush_entry = tag_rd[flush_way];
    assign flush_dirty = flush_entry.valid && flush_entry.dirty;

    for (genvar w = 0; w < 2; w++) begin : g_way
        way_store #(.payload_t(dcache_pkg::frame_tag_t), .SET_BITS(SET_BITS)) u_tags (
            .CLK, .nRST, .wen(tag_wen[w]), .widx(rd_idx), .wdata(new_tag),
            .ridx(rd_idx), .rdata(tag_rd[w])
        );
        way_store #(.payload_t(dcache_pkg::block_t), .SET_BITS(SET_BITS)) u_data (
            .CLK, .nRST, .wen(data_wen[w]), .widx(rd_idx), .wdata(new_block),
            .ridx(rd_idx), .rdata(data_rd[w])
        );
    end

    way_select #(.SET_BITS(SET_BITS)) u_select (
        .CLK, .nRST, .req_tag, .req_idx, .entry0(tag_rd[0]), .entry1(tag_rd[1]),
        .lru_update, .lru_way, .hit, .hit_way, .victim_way, .victim_dirty
    );

    flush_counter #(.SET_BITS(SET_BITS)) u_flush (
        .CLK, .nRST, .flush_step, .flush_idx, .flush_way, .flush_done
    );

    dcache_fsm #(.SET_BITS(SET_BITS)) u_fsm (
        .CLK, .nRST, .dmemREN, .dmemWEN, .halt, .dwait,
        .hit, .victim_dirty, .flush_dirty, .flush_done,
        .hit_way, .victim_way, .flush_way,
        .dmemaddr, .dmemstore, .dload,
        .hit_block(data_rd[hit_way]), .victim_block(data_rd[victim_way]),
        .flush_block(data_rd[flush_way]),
        .victim_tag(tag_rd[victim_way].tag), .flush_tag(flush_entry.tag), .flush_idx,
        .dhit, .flushed, .dREN, .dWEN, .daddr, .dstore, .dmemload,
        .tag_wen, .data_wen, .new_tag, .new_block,
        .lru_update, .lru_way, .flush_step, .flush_active
    );

endmodule

`default_nettype wire

// ==== hdl/flush_counter.sv ====
// frame counter for the halt flush
// low bits pick the set and the top counted bit picks the way
`default_nettype none

module flush_counter #(
    parameter int SET_BITS = dcache_pkg::IDX_W
) (
    input  wire logic                CLK,
    input  wire logic                nRST,
    input  wire logic                flush_step,
    output logic [SET_BITS-1:0]      flush_idx,
    output logic                     flush_way,
    output logic                     flush_done
);

    // one extra bit above the way marks the pass over the last frame
    logic [SET_BITS+1:0] count;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (flush_step) begin
            count <= count + 1'b1;
        end
    end

    assign flush_idx  = count[SET_BITS-1:0];
    assign flush_way  = count[SET_BITS];
    assign flush_done = count[SET_BITS+1];

endmodule

`default_nettype wire

// ==== hdl/way_select.sv ====
// tag compare, hit way, victim choice and the per-set LRU bits
// each LRU bit names the way to evict next in its set
`default_nettype none

module way_select #(
    parameter int SET_BITS = dcache_pkg::IDX_W
) (
    input  wire logic                          CLK,
    input  wire logic                          nRST,
    input  wire logic [dcache_pkg::TAG_W-1:0]  req_tag,
    input  wire logic [SET_BITS-1:0]           req_idx,
    input  wire dcache_pkg::frame_tag_t        entry0,
    input  wire dcache_pkg::frame_tag_t        entry1,
    input  wire logic                          lru_update,
    input  wire logic                          lru_way,
    output logic                               hit,
    output logic                               hit_way,
    output logic                               victim_way,
    output logic                               victim_dirty
);

    logic [2**SET_BITS-1:0] lru;
    logic                   match0;
    logic                   match1;

    assign match0 = entry0.valid && (entry0.tag == req_tag);
    assign match1 = entry1.valid && (entry1.tag == req_tag);

    // way 0 wins if both match
    assign hit     = match0 || match1;
    assign hit_way = !match0 && match1;

    assign victim_way = lru[req_idx];

    always_comb begin
        if (victim_way) begin
            victim_dirty = entry1.valid && entry1.dirty;
        end else begin
            victim_dirty = entry0.valid && entry0.dirty;
        end
    end

    // the way just used becomes most recent
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lru <= '0;
        end else if (lru_update) begin
            lru[req_idx] <= !lru_way;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/way_store.sv ====
// per-set storage for one cache way that holds either tag entries or data blocks
// written on the clock edge and read combinationally by index
`default_nettype none

module way_store #(
    parameter type payload_t = dcache_pkg::word_t,
    parameter int  SET_BITS  = dcache_pkg::IDX_W
) (
    input  wire logic                CLK,
    input  wire logic                nRST,
    input  wire logic                wen,
    input  wire logic [SET_BITS-1:0] widx,
    input  wire payload_t            wdata,
    input  wire logic [SET_BITS-1:0] ridx,
    output payload_t                 rdata
);

    localparam int SETS = 2**SET_BITS;

    payload_t mem [SETS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < SETS; i++) begin
                mem[i] <= '0;
            end
        end else if (wen) begin
            mem[widx] <= wdata;
        end
    end

    assign rdata = mem[ridx];

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# builds the data cache testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    -f all.f --top-module dcache_tb -o sim_dcache
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/sim_dcache 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

// ==== tests/dcache_tb.sv ====
// testbench for the two-way data cache with random reads and writes against a shadow memory
// and a residency model for hit and writeback checks, ending with the halt flush
`default_nettype none

module dcache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int SETS = 8;

    logic CLK;
    logic nRST;
    logic dmemREN;
    logic dmemWEN;
    logic halt;
    logic dhit;
    logic flushed;
    logic dREN;
    logic dWEN;
    logic dwait;
    dcache_pkg::word_t dmemaddr;
    dcache_pkg::word_t dmemstore;
    dcache_pkg::word_t dmemload;
    dcache_pkg::word_t daddr;
    dcache_pkg::word_t dstore;
    dcache_pkg::word_t dload;

    // shadow memory plus what the cache should be holding per set and way
    dcache_pkg::word_t            shadow [256];
    logic [dcache_pkg::TAG_W-1:0] res_tag [SETS][2];
    logic                         res_valid [SETS][2];
    logic                         res_dirty [SETS][2];
    logic                         res_lru [SETS];

    dcache_top DUT (
        .CLK, .nRST, .dmemREN, .dmemWEN, .halt, .dmemaddr, .dmemstore,
        .dhit, .flushed, .dmemload, .dREN, .dWEN, .daddr, .dstore, .dwait, .dload
    );

    mem_model u_mem (
        .CLK, .nRST, .dREN, .dWEN, .daddr, .dstore, .dwait, .dload
    );

    always #2 CLK = ~CLK;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic compare_word(input string name, input dcache_pkg::word_t expected,
                                input dcache_pkg::word_t actual);
        assert (expected === actual)
            else abort_run($sformatf("MISMATCH %s expected %h actual %h",
                                     name, expected, actual));
    endtask

    // issues one processor request and holds it until dhit while checking the memory traffic
    task automatic cache_access(input string name, input logic is_write,
                                input dcache_pkg::word_t addr, input dcache_pkg::word_t data);
        logic [2:0]                   set;
        logic [dcache_pkg::TAG_W-1:0] tag;
        logic                         way;
        logic                         vway;
        logic                         resident;
        logic                         mem_seen;
        logic                         got_hit;
        int                           wb_count;
        int                           writes;
        int                           cycles;
        dcache_pkg::word_t            wb_base;
        set      = addr[5:3];
        tag      = addr[31:6];
        resident = 1'b0;
        way      = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (!resident && res_valid[set][w] && res_tag[set][w] == tag) begin
                resident = 1'b1;
                way      = 1'(w);
            end
        end
        vway     = res_lru[set];
        wb_count = (!resident && res_valid[set][vway] && res_dirty[set][vway]) ? 2 : 0;
        wb_base  = {res_tag[set][vway], set, 3'b000};

        @(posedge CLK);
        dmemREN   <= !is_write;
        dmemWEN   <= is_write;
        dmemaddr  <= addr;
        dmemstore <= data;
        writes    = 0;
        cycles    = 0;
        mem_seen  = 1'b0;
        got_hit   = 1'b0;
        while (!got_hit) begin
            @(negedge CLK);
            if (dREN || dWEN) begin
                mem_seen = 1'b1;
            end
            assert (!(dREN && writes < wb_count))
                else abort_run({name, ": fill read issued before the victim writeback"});
            if (dWEN && !dwait) begin
                assert (writes < wb_count)
                    else abort_run({name, ": unexpected memory write during the miss"});
                compare_word({name, " writeback address"}, wb_base | (writes << 2), daddr);
                compare_word({name, " writeback data"}, shadow[daddr[9:2]], dstore);
                writes++;
            end
            got_hit = dhit;
            cycles++;
            assert (cycles < 200) else abort_run({name, ": timed out waiting for dhit"});
        end
        assert (!(resident && mem_seen))
            else abort_run({name, ": memory accessed for a block held in the cache"});
        compare_word({name, " writeback count"}, wb_count, writes);
        if (!is_write) begin
            compare_word(name, shadow[addr[9:2]], dmemload);
        end
        @(posedge CLK);
        dmemREN <= 1'b0;
        dmemWEN <= 1'b0;

        // update the model the same way the LRU rule does
        if (!resident) begin
            way                 = vway;
            res_valid[set][way] = 1'b1;
            res_tag[set][way]   = tag;
            res_dirty[set][way] = 1'b0;
        end
        if (is_write) begin
            res_dirty[set][way] = 1'b1;
            shadow[addr[9:2]]   = data;
        end
        res_lru[set] = !way;
    endtask

    task automatic flush_and_verify();
        int cycles;
        @(posedge CLK);
        halt   <= 1'b1;
        cycles = 0;
        @(negedge CLK);
        while (!flushed) begin
            cycles++;
            assert (cycles < 200) else abort_run("flushed did not rise after halt");
            @(negedge CLK);
        end
        repeat (20) begin
            @(negedge CLK);
            assert (!dWEN) else abort_run("memory write seen after flushed was high");
        end
        for (int i = 0; i < 256; i++) begin
            compare_word($sformatf("flush word %0d", i), shadow[i], u_mem.mem[i]);
        end
    endtask

    initial begin
        dcache_pkg::word_t addr;
        CLK       = 1'b0;
        nRST      = 1'b0;
        dmemREN   = 1'b0;
        dmemWEN   = 1'b0;
        halt      = 1'b0;
        dmemaddr  = '0;
        dmemstore = '0;
        void'($urandom(32'h605d_cf16));
        for (int i = 0; i < 256; i++) begin
            shadow[i] = i ^ 32'h5a5a_0000;
        end
        for (int s = 0; s < SETS; s++) begin
            res_lru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                res_valid[s][w] = 1'b0;
                res_dirty[s][w] = 1'b0;
                res_tag[s][w]   = '0;
            end
        end

        repeat (4) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        assert (!dREN && !dWEN && !dhit && !flushed)
            else abort_run("cache outputs not idle after reset");

        // two dirty frames fill set 0 and a third tag forces a dirty eviction
        cache_access("store tag 0", 1'b1, 32'h0000_0000, 32'hcafe_0001);
        cache_access("store tag 1", 1'b1, 32'h0000_0044, 32'hcafe_0002);
        cache_access("dirty eviction", 1'b0, 32'h0000_0080, '0);
        cache_access("resident read", 1'b0, 32'h0000_0040, '0);
        cache_access("clean eviction", 1'b0, 32'h0000_00c4, '0);

        for (int n = 0; n < 300; n++) begin
            addr      = '0;
            addr[8:6] = 3'($urandom_range(0, 5));
            addr[5:3] = 3'($urandom_range(0, 7));
            addr[2]   = 1'($urandom_range(0, 1));
            cache_access($sformatf("random %0d", n), 1'($urandom_range(0, 1)), addr, $urandom);
        end

        flush_and_verify();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/mem_model.sv ====
// 256-word memory behind the cache that answers dREN and dWEN after a random delay
// dwait drops for one cycle per word and a write lands on the edge that ends that cycle
`default_nettype none

module mem_model (
    input  wire logic               CLK,
    input  wire logic               nRST,
    input  wire logic               dREN,
    input  wire logic               dWEN,
    input  wire dcache_pkg::word_t  daddr,
    input  wire dcache_pkg::word_t  dstore,
    output logic                    dwait,
    output dcache_pkg::word_t       dload
);
    timeunit 1ns;
    timeprecision 1ps;

    dcache_pkg::word_t mem [256];
    logic ready = 1'b0;
    int   delay = 0;

    // each word starts as its word address with a marker in the upper half
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = i ^ 32'h5a5a_0000;
        end
    end

    assign dwait = !ready;
    assign dload = mem[daddr[9:2]];

    always @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ready <= 1'b0;
            delay <= 0;
        end else if (ready) begin
            if (dWEN) begin
                mem[daddr[9:2]] <= dstore;
            end
            ready <= 1'b0;
            delay <= $urandom_range(0, 2);
        end else if (dREN || dWEN) begin
            if (delay == 0) begin
                ready <= 1'b1;
            end else begin
                delay <= delay - 1;
            end
        end
    end

endmodule

`default_nettype wire
